// ==== verilog/udp_pkg.sv ====
package udp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;

    typedef enum logic [3:0] {
        uninited,
        arp_req_s,
        arp_wait,
        check_mac,
        idle,
        gen_req,
        write_idx1,
        write_idx2,
        write_data
    } sender_state_t;

    localparam logic [15:0] ETH_ARP = 16'h0806;
    localparam logic [15:0] ETH_IP  = 16'h0800;

    localparam int UDP_HDR_BYTES   = 28;
    localparam int ARP_FRAME_BYTES = 22;
    // UDP length covers its own 8 byte header
    localparam int UDP_OVERHEAD    = 8;

    // Wide enough for a wait period and for a payload count
    function automatic int timer_width(int cycles);
        int w;
        w = $clog2(cycles);
        return (w > $bits(len_t)) ? w : $bits(len_t);
    endfunction

endpackage : udp_pkg

// ==== verilog/udp_link_if.sv ====
interface udp_link_if;
    import udp_pkg::*;

    logic  app_request;
    logic  send_ack;
    logic  app_valid;
    byte_t app_data;
    len_t  app_length;
    logic  arp_req;
    logic  arp_found;
    logic  mac_not_exist;

    modport ctrl (
        output app_request, app_valid, app_data, app_length, arp_req,
        input  send_ack, arp_found, mac_not_exist
    );

    modport tx (
        input  app_request, app_valid, app_data, app_length, arp_req,
        output send_ack
    );

    modport rx (
        input  arp_req,
        output arp_found, mac_not_exist
    );

endinterface : udp_link_if

// ==== verilog/link_timer.sv ====
module link_timer #(
    parameter int WAIT_CYCLES = 200
) (
    input  logic                                          rgmii_clk,
    input  logic                                          arp_rstn,
    input  logic                                          clear,
    input  logic                                          step,
    output logic [udp_pkg::timer_width(WAIT_CYCLES)-1:0] count,
    output logic                                          expired
);
    import udp_pkg::*;

    localparam int CNT_W = timer_width(WAIT_CYCLES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WAIT_CYCLES - 1);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == LAST);

    // The FSM must clear the counter at every period end and keep
    // payload lengths below one period
    a_count_bound: assert property (
        @(posedge rgmii_clk) disable iff (!arp_rstn)
        count <= LAST
    ) else $error("link_timer count %0d passed %0d", count, LAST);

endmodule : link_timer

// ==== verilog/sender_fsm.sv ====
module sender_fsm #(
    parameter int WAIT_CYCLES = 200
) (
    input  logic            rgmii_clk,
    input  logic            arp_rstn,
    input  logic            trig,
    input  logic [15:0]     index,
    input  udp_pkg::len_t   data_len,
    input  logic            valid,
    input  udp_pkg::byte_t  data,
    output logic            read_en,
    output logic            connected,
    udp_link_if.ctrl        link
);
    import udp_pkg::*;

    localparam int CNT_W = timer_width(WAIT_CYCLES);

    sender_state_t    state;
    logic             timer_clear;
    logic             timer_step;
    logic             timer_expired;
    logic [CNT_W-1:0] count;
    logic             payload_done;

    link_timer #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) u_link_timer (
        .rgmii_clk(rgmii_clk),
        .arp_rstn (arp_rstn),
        .clear    (timer_clear),
        .step     (timer_step),
        .count    (count),
        .expired  (timer_expired)
    );

    assign payload_done    = (count == CNT_W'(data_len));
    // Two index bytes lead the payload
    assign link.app_length = data_len + len_t'(2);

    always_comb begin
        timer_clear = 1'b0;
        timer_step  = 1'b0;
        case (state)
            uninited: begin
                timer_clear = timer_expired;
                timer_step  = !timer_expired;
            end
            arp_req_s: timer_clear = 1'b1;
            arp_wait: begin
                timer_clear = link.arp_found || timer_expired;
                timer_step  = !(link.arp_found || timer_expired);
            end
            check_mac: begin
                // No MAC: keep count at the end so uninited expires at once
                timer_clear = timer_expired && !link.mac_not_exist;
                timer_step  = !timer_expired;
            end
            write_idx2: timer_clear = 1'b1;
            write_data: timer_step = valid && !payload_done;
            default: ;
        endcase
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            state            <= uninited;
            connected        <= 1'b0;
            read_en          <= 1'b0;
            link.arp_req     <= 1'b0;
            link.app_request <= 1'b0;
            link.app_valid   <= 1'b0;
        end else begin
            link.arp_req <= 1'b0;
            case (state)
                uninited: begin
                    connected <= 1'b0;
                    if (timer_expired) begin
                        state <= arp_req_s;
                    end
                end
                arp_req_s: begin
                    link.arp_req <= 1'b1;
                    state        <= arp_wait;
                end
                arp_wait: begin
                    if (link.arp_found) begin
                        state <= check_mac;
                    end else if (timer_expired) begin
                        state <= uninited;
                    end
                end
                check_mac: begin
                    if (timer_expired) begin
                        state <= link.mac_not_exist ? uninited : idle;
                    end
                end
                idle: begin
                    connected      <= 1'b1;
                    read_en        <= 1'b0;
                    link.app_valid <= 1'b0;
                    if (trig && connected) begin
                        state <= gen_req;
                    end
                end
                gen_req: begin
                    if (link.send_ack) begin
                        link.app_request <= 1'b0;
                        state            <= write_idx1;
                    end else begin
                        link.app_request <= 1'b1;
                    end
                end
                write_idx1: begin
                    link.app_valid <= 1'b1;
                    state          <= write_idx2;
                end
                write_idx2: begin
                    link.app_valid <= 1'b1;
                    if (data_len != '0) begin
                        read_en <= 1'b1;
                        state   <= write_data;
                    end else begin
                        state <= idle;
                    end
                end
                write_data: begin
                    if (payload_done) begin
                        read_en        <= 1'b0;
                        link.app_valid <= 1'b0;
                        state          <= idle;
                    end else begin
                        link.app_valid <= valid;
                    end
                end
                default: state <= uninited;
            endcase
        end
    end

    always_ff @(posedge rgmii_clk) begin
        case (state)
            write_idx1: link.app_data <= index[15:8];
            write_idx2: link.app_data <= index[7:0];
            default:    link.app_data <= data;
        endcase
    end

    a_read_window: assert property (
        @(posedge rgmii_clk) disable iff (!arp_rstn)
        read_en |-> (state == write_data) && ($past(state) inside {write_idx2, write_data})
    ) else $error("read_en high outside the payload window");

endmodule : sender_fsm

// ==== verilog/frame_tx.sv ====
module frame_tx #(
    parameter udp_pkg::mac_addr_t LOCAL_MAC  = 48'h11_11_11_11_11_11,
    parameter udp_pkg::ip_addr_t  LOCAL_IP   = 32'hC0_A8_01_6E,
    parameter udp_pkg::udp_port_t LOCAL_PORT = 16'h8080,
    parameter udp_pkg::ip_addr_t  DEST_IP    = 32'hC0_A8_01_69,
    parameter udp_pkg::udp_port_t DEST_PORT  = 16'h8080
) (
    input  logic               rgmii_clk,
    input  logic               arp_rstn,
    udp_link_if.tx             link,
    input  udp_pkg::mac_addr_t peer_mac,
    output logic               tx_valid,
    output udp_pkg::byte_t     tx_data,
    output logic               tx_last
);
    import udp_pkg::*;

    localparam int HDR_W = 8 * UDP_HDR_BYTES;
    localparam int PAD_W = 8 * (UDP_HDR_BYTES - ARP_FRAME_BYTES);

    typedef enum logic [1:0] {
        ft_idle,
        ft_arp,
        ft_udp,
        ft_app
    } ft_state_t;

    ft_state_t        state;
    logic [4:0]       hdr_cnt;
    len_t             app_cnt;
    len_t             udp_len;
    logic [HDR_W-1:0] arp_frame;
    logic [HDR_W-1:0] udp_frame;
    logic [HDR_W-1:0] start_frame;
    logic [HDR_W-1:0] hdr_shift;
    byte_t            next_byte;

    assign udp_len   = link.app_length + len_t'(UDP_OVERHEAD);
    // ARP frame left aligned so both kinds shift out from the top
    assign arp_frame = {48'hFFFF_FFFF_FFFF, LOCAL_MAC, ETH_ARP, LOCAL_IP, DEST_IP,
                        {PAD_W{1'b0}}};
    assign udp_frame = {peer_mac, LOCAL_MAC, ETH_IP, LOCAL_IP, DEST_IP,
                        LOCAL_PORT, DEST_PORT, udp_len};

    assign start_frame = link.arp_req ? arp_frame : udp_frame;

    always_comb begin
        case (state)
            ft_idle: next_byte = start_frame[HDR_W-1 -: 8];
            ft_app:  next_byte = link.app_data;
            default: next_byte = hdr_shift[HDR_W-1 -: 8];
        endcase
    end

    always_ff @(posedge rgmii_clk) begin
        tx_data <= next_byte;
        if (state == ft_idle) begin
            hdr_shift <= start_frame << 8;
        end else begin
            hdr_shift <= hdr_shift << 8;
        end
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            state         <= ft_idle;
            hdr_cnt       <= '0;
            app_cnt       <= '0;
            tx_valid      <= 1'b0;
            tx_last       <= 1'b0;
            link.send_ack <= 1'b0;
        end else begin
            tx_valid      <= 1'b0;
            tx_last       <= 1'b0;
            link.send_ack <= 1'b0;
            case (state)
                ft_idle: begin
                    // Byte 0 goes out on this edge
                    hdr_cnt <= 5'd1;
                    if (link.arp_req) begin
                        tx_valid <= 1'b1;
                        state    <= ft_arp;
                    end else if (link.app_request) begin
                        tx_valid <= 1'b1;
                        state    <= ft_udp;
                    end
                end
                ft_arp: begin
                    tx_valid <= 1'b1;
                    hdr_cnt  <= hdr_cnt + 5'd1;
                    if (hdr_cnt == 5'(ARP_FRAME_BYTES - 1)) begin
                        tx_last <= 1'b1;
                        state   <= ft_idle;
                    end
                end
                ft_udp: begin
                    tx_valid <= 1'b1;
                    hdr_cnt  <= hdr_cnt + 5'd1;
                    app_cnt  <= '0;
                    if (hdr_cnt == 5'(UDP_HDR_BYTES - 1)) begin
                        link.send_ack <= 1'b1;
                        state         <= ft_app;
                    end
                end
                ft_app: begin
                    tx_valid <= link.app_valid;
                    if (link.app_valid) begin
                        app_cnt <= app_cnt + len_t'(1);
                        if (app_cnt == link.app_length - len_t'(1)) begin
                            tx_last <= 1'b1;
                            state   <= ft_idle;
                        end
                    end
                end
                default: state <= ft_idle;
            endcase
        end
    end

    a_last_valid: assert property (
        @(posedge rgmii_clk) disable iff (!arp_rstn)
        tx_last |-> tx_valid
    ) else $error("tx_last without tx_valid");

endmodule : frame_tx

// ==== verilog/arp_rx.sv ====
module arp_rx #(
    parameter udp_pkg::ip_addr_t DEST_IP = 32'hC0_A8_01_69
) (
    input  logic               rgmii_clk,
    input  logic               arp_rstn,
    input  logic               rx_valid,
    input  udp_pkg::byte_t     rx_data,
    udp_link_if.rx             link,
    output udp_pkg::mac_addr_t peer_mac
);
    import udp_pkg::*;

    localparam logic [4:0] MIN_BYTES = 5'd18;

    logic [4:0]  rx_cnt;
    logic        hdr_ok;
    logic        mac_stored;
    logic        accept;
    mac_addr_t   src_mac;
    logic [47:0] match_word;
    logic [2:0]  match_idx;
    byte_t       match_byte;

    // Ethertype then sender IP, bytes 12 to 17
    assign match_word = {ETH_ARP, DEST_IP};
    assign match_idx  = 3'(5'd17 - rx_cnt);
    assign match_byte = byte_t'(match_word >> {match_idx, 3'b000});

    // Frame just ended with enough bytes and every check passed
    assign accept = !rx_valid && (rx_cnt == MIN_BYTES) && hdr_ok;

    assign link.mac_not_exist = !mac_stored;

    always_ff @(posedge rgmii_clk) begin
        if (rx_valid && rx_cnt >= 5'd6 && rx_cnt < 5'd12) begin
            src_mac <= {src_mac[39:0], rx_data};
        end
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            rx_cnt         <= '0;
            hdr_ok         <= 1'b1;
            mac_stored     <= 1'b0;
            peer_mac       <= '0;
            link.arp_found <= 1'b0;
        end else begin
            link.arp_found <= accept;
            if (rx_valid) begin
                if (rx_cnt != MIN_BYTES) begin
                    rx_cnt <= rx_cnt + 5'd1;
                end
                if (rx_cnt >= 5'd12 && rx_cnt < MIN_BYTES && rx_data != match_byte) begin
                    hdr_ok <= 1'b0;
                end
            end else begin
                rx_cnt <= '0;
                hdr_ok <= 1'b1;
            end
            // A new request drops any older peer
            if (link.arp_req) begin
                mac_stored <= 1'b0;
                peer_mac   <= '0;
            end else if (accept) begin
                mac_stored <= 1'b1;
                peer_mac   <= src_mac;
            end
        end
    end

endmodule : arp_rx

// ==== verilog/udp_sender.sv ====
module udp_sender #(
    parameter udp_pkg::mac_addr_t LOCAL_MAC       = 48'h11_11_11_11_11_11,
    parameter udp_pkg::ip_addr_t  LOCAL_IP        = 32'hC0_A8_01_6E,
    parameter udp_pkg::udp_port_t LOCAL_PORT      = 16'h8080,
    parameter udp_pkg::ip_addr_t  DEST_IP         = 32'hC0_A8_01_69,
    parameter udp_pkg::udp_port_t DEST_PORT       = 16'h8080,
    // Default is 200 ms at 125 MHz
    parameter int                 ARP_WAIT_CYCLES = 25_000_000
) (
    input  logic           rgmii_clk,
    input  logic           arp_rstn,
    input  logic           trig,
    input  logic [15:0]    index,
    output logic           read_en,
    input  logic           valid,
    input  udp_pkg::byte_t data,
    input  udp_pkg::len_t  data_len,
    output logic           connected,
    input  logic           rx_valid,
    input  udp_pkg::byte_t rx_data,
    output logic           tx_valid,
    output udp_pkg::byte_t tx_data,
    output logic           tx_last
);
    import udp_pkg::*;

    mac_addr_t peer_mac;

    udp_link_if u_link ();

    sender_fsm #(
        .WAIT_CYCLES(ARP_WAIT_CYCLES)
    ) u_sender_fsm (
        .rgmii_clk(rgmii_clk),
        .arp_rstn (arp_rstn),
        .trig     (trig),
        .index    (index),
        .data_len (data_len),
        .valid    (valid),
        .data     (data),
        .read_en  (read_en),
        .connected(connected),
        .link     (u_link.ctrl)
    );

    frame_tx #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .LOCAL_PORT(LOCAL_PORT),
        .DEST_IP   (DEST_IP),
        .DEST_PORT (DEST_PORT)
    ) u_frame_tx (
        .rgmii_clk(rgmii_clk),
        .arp_rstn (arp_rstn),
        .link     (u_link.tx),
        .peer_mac (peer_mac),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_last  (tx_last)
    );

    arp_rx #(
        .DEST_IP(DEST_IP)
    ) u_arp_rx (
        .rgmii_clk(rgmii_clk),
        .arp_rstn (arp_rstn),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .link     (u_link.rx),
        .peer_mac (peer_mac)
    );

endmodule : udp_sender

// ==== dv/tb_checker.sv ====
module tb_checker #(
    parameter logic [47:0] LOCAL_MAC  = 48'h0,
    parameter logic [31:0] LOCAL_IP   = 32'h0,
    parameter logic [15:0] LOCAL_PORT = 16'h0,
    parameter logic [31:0] DEST_IP    = 32'h0,
    parameter logic [15:0] DEST_PORT  = 16'h0
) (
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  logic [15:0] index,
    input  logic [15:0] data_len,
    input  logic        read_en,
    input  logic        valid,
    input  logic [7:0]  data,
    input  logic        connected,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    input  logic        tx_valid,
    input  logic [7:0]  tx_data,
    input  logic        tx_last,
    output int          err_count,
    output int          check_count,
    output int          arp_frames,
    output int          udp_frames
);
    timeunit 1ns;
    timeprecision 1ps;

    int          errs = 0;
    int          checks = 0;
    int          n_arp = 0;
    int          n_udp = 0;
    logic [7:0]  rx_buf[$];
    logic [7:0]  tx_buf[$];
    logic [7:0]  exp_buf[$];
    logic [7:0]  accepted[$];
    logic [47:0] model_peer = '0;
    logic        has_peer = 1'b0;
    logic        in_frame = 1'b0;
    logic        frame_udp = 1'b0;
    logic        read_seen = 1'b0;
    logic        conn_d = 1'b0;

    assign err_count   = errs;
    assign check_count = checks;
    assign arp_frames  = n_arp;
    assign udp_frames  = n_udp;

    // Reply rule: at least 18 bytes, ARP ethertype, then the destination IP
    function automatic logic reply_ok();
        logic [47:0] want;
        int i;
        want = {16'h0806, DEST_IP};
        if (rx_buf.size() < 18) begin
            return 1'b0;
        end
        for (i = 0; i < 6; i++) begin
            if (rx_buf[12 + i] != want[47 - 8*i -: 8]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic void push_bytes(input logic [47:0] value, input int n);
        int i;
        for (i = n - 1; i >= 0; i--) begin
            exp_buf.push_back(value[8*i +: 8]);
        end
    endfunction

    function automatic void build_expected();
        int i;
        exp_buf.delete();
        if (frame_udp) begin
            push_bytes(model_peer, 6);
            push_bytes(LOCAL_MAC, 6);
            push_bytes(48'h0800, 2);
            push_bytes(48'(LOCAL_IP), 4);
            push_bytes(48'(DEST_IP), 4);
            push_bytes(48'(LOCAL_PORT), 2);
            push_bytes(48'(DEST_PORT), 2);
            // UDP header and index on top of the payload
            push_bytes(48'(data_len + 16'd10), 2);
            push_bytes(48'(index), 2);
            for (i = 0; i < int'(data_len) && i < accepted.size(); i++) begin
                exp_buf.push_back(accepted[i]);
            end
        end else begin
            push_bytes(48'hFFFF_FFFF_FFFF, 6);
            push_bytes(LOCAL_MAC, 6);
            push_bytes(48'h0806, 2);
            push_bytes(48'(LOCAL_IP), 4);
            push_bytes(48'(DEST_IP), 4);
        end
    endfunction

    task automatic finish_frame();
        int i;
        string kind;
        build_expected();
        kind = frame_udp ? "UDP" : "ARP";
        checks++;
        if (tx_buf.size() != exp_buf.size()) begin
            errs++;
            $display("Mismatch tx_last in %s frame: length %0h, expected %0h",
                     kind, tx_buf.size(), exp_buf.size());
        end
        for (i = 0; i < tx_buf.size() && i < exp_buf.size(); i++) begin
            checks++;
            if (tx_buf[i] !== exp_buf[i]) begin
                errs++;
                $display("Mismatch tx_data in %s frame byte %0d: got %02h, expected %02h",
                         kind, i, tx_buf[i], exp_buf[i]);
            end
        end
        if (frame_udp) begin
            checks++;
            if (accepted.size() < int'(data_len)) begin
                errs++;
                $display("Only %0d of %0d payload bytes were accepted before read_en fell",
                         accepted.size(), data_len);
            end
        end
        if (frame_udp && data_len == 16'd0) begin
            checks++;
            if (read_seen) begin
                errs++;
                $display("Mismatch read_en in a frame with data_len 0: got 1, expected 0");
            end
        end
        if (frame_udp) begin
            n_udp++;
        end else begin
            n_arp++;
        end
        tx_buf.delete();
        accepted.delete();
    endtask

    always @(posedge rgmii_clk) begin
        if (!arp_rstn) begin
            checks++;
            if (connected !== 1'b0 || tx_valid !== 1'b0 || read_en !== 1'b0) begin
                errs++;
                $display("Mismatch in reset: connected %0h tx_valid %0h read_en %0h, expected 0",
                         connected, tx_valid, read_en);
            end
        end else begin
            if (rx_valid) begin
                rx_buf.push_back(rx_data);
            end else if (rx_buf.size() > 0) begin
                if (reply_ok()) begin
                    model_peer = {rx_buf[6], rx_buf[7], rx_buf[8],
                                  rx_buf[9], rx_buf[10], rx_buf[11]};
                    has_peer   = 1'b1;
                end
                rx_buf.delete();
            end

            if (connected && !conn_d) begin
                checks++;
                if (!has_peer) begin
                    errs++;
                    $display("Mismatch connected without a valid ARP reply: got 1, expected 0");
                end
            end
            conn_d = connected;

            if (read_en && valid) begin
                accepted.push_back(data);
            end

            if (tx_valid) begin
                if (!in_frame) begin
                    in_frame  = 1'b1;
                    frame_udp = connected;
                    read_seen = 1'b0;
                    // A new ARP request drops the stored peer
                    if (!connected) begin
                        has_peer = 1'b0;
                    end
                end
                tx_buf.push_back(tx_data);
                if (tx_last) begin
                    finish_frame();
                    in_frame = 1'b0;
                end
            end else if (in_frame && !frame_udp) begin
                errs++;
                $display("Gap inside an ARP request frame at byte %0d", tx_buf.size());
            end

            if (read_en) begin
                read_seen = 1'b1;
            end
        end
    end

endmodule : tb_checker

// ==== dv/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [47:0] LOCAL_MAC    = 48'h02_1A_2B_3C_4D_5E;
    localparam logic [31:0] LOCAL_IP     = 32'hC0_A8_01_6E;
    localparam logic [15:0] LOCAL_PORT   = 16'h8080;
    localparam logic [31:0] DEST_IP      = 32'hC0_A8_01_69;
    localparam logic [15:0] DEST_PORT    = 16'h1F90;
    localparam int          WAIT_CYCLES  = 200;
    localparam int          ARP_FRAMES   = 4;
    localparam int          UDP_FRAMES   = 23;
    // Twenty wait periods plus 100 cycles for every frame
    localparam int          LIMIT_CYCLES = 20 * WAIT_CYCLES + 100 * (ARP_FRAMES + UDP_FRAMES);

    logic        rgmii_clk;
    logic        arp_rstn;
    logic        trig;
    logic [15:0] index;
    logic        read_en;
    logic        valid;
    logic [7:0]  data;
    logic [15:0] data_len;
    logic        connected;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        tx_last;
    int          err_count;
    int          check_count;
    int          arp_frames;
    int          udp_frames;

    integer      seed;
    int          tests_run;
    int          errs_at_start;
    logic        gap_mode;
    int          k;
    logic [31:0] w;
    logic [47:0] mac;

    udp_sender #(
        .LOCAL_MAC      (LOCAL_MAC),
        .LOCAL_IP       (LOCAL_IP),
        .LOCAL_PORT     (LOCAL_PORT),
        .DEST_IP        (DEST_IP),
        .DEST_PORT      (DEST_PORT),
        .ARP_WAIT_CYCLES(WAIT_CYCLES)
    ) u_dut (.*);

    tb_checker #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .LOCAL_PORT(LOCAL_PORT),
        .DEST_IP   (DEST_IP),
        .DEST_PORT (DEST_PORT)
    ) u_checker (.*);

    initial begin
        rgmii_clk = 1'b0;
        forever begin
            #5 rgmii_clk = ~rgmii_clk;
        end
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r % 32'(n));
    endfunction

    task automatic start_test();
        errs_at_start = err_count;
    endtask

    task automatic end_test(input string name);
        int n;
        n = err_count - errs_at_start;
        tests_run++;
        if (n == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, n);
        end
    endtask

    task automatic wait_arp(input int n);
        while (arp_frames < n) begin
            @(negedge rgmii_clk);
        end
    endtask

    // Bytes 0 to 17 from the fields, random filler after them
    task automatic send_reply(input logic [47:0] src, input logic [15:0] etype,
                              input logic [31:0] ip, input int nbytes);
        logic [143:0] hdr;
        int i;
        hdr = {LOCAL_MAC, src, etype, ip};
        for (i = 0; i < nbytes; i++) begin
            @(negedge rgmii_clk);
            rx_valid = 1'b1;
            rx_data  = (i < 18) ? hdr[143 - 8*i -: 8] : 8'(rand_below(256));
        end
        @(negedge rgmii_clk);
        rx_valid = 1'b0;
        rx_data  = '0;
    endtask

    task automatic send_frame(input logic [15:0] idx, input logic [15:0] len);
        int target;
        target = udp_frames + 1;
        @(negedge rgmii_clk);
        index    = idx;
        data_len = len;
        trig     = 1'b1;
        @(negedge rgmii_clk);
        trig = 1'b0;
        while (udp_frames < target) begin
            data  = 8'(rand_below(256));
            valid = read_en && (!gap_mode || rand_below(4) != 0);
            @(negedge rgmii_clk);
        end
        valid = 1'b0;
        repeat (2 + rand_below(4)) @(negedge rgmii_clk);
    endtask

    initial begin
        seed          = 32'h26d364e7;
        arp_rstn      = 1'b1;
        trig          = 1'b0;
        index         = '0;
        data_len      = '0;
        valid         = 1'b0;
        data          = '0;
        rx_valid      = 1'b0;
        rx_data       = '0;
        gap_mode      = 1'b0;
        tests_run     = 0;
        errs_at_start = 0;
        #1 arp_rstn = 1'b0;
        repeat (8) @(negedge rgmii_clk);
        arp_rstn = 1'b1;

        start_test();
        wait_arp(1);
        end_test("reset and first ARP request");

        start_test();
        for (k = 0; k < 3; k++) begin
            w   = rand_word();
            mac = {w[15:0], rand_word()};
            case (k)
                0: send_reply(mac, 16'h0800, DEST_IP, 18 + rand_below(6));
                1: send_reply(mac, 16'h0806, DEST_IP ^ (32'd1 << rand_below(32)),
                              18 + rand_below(6));
                default: send_reply(mac, 16'h0806, DEST_IP, 12 + rand_below(6));
            endcase
            wait_arp(k + 2);
        end
        end_test("corrupted replies do not connect");

        start_test();
        w   = rand_word();
        mac = {w[15:0], rand_word()};
        send_reply(mac, 16'h0806, DEST_IP, 18 + rand_below(8));
        while (!connected) begin
            @(negedge rgmii_clk);
        end
        end_test("valid reply connects");

        start_test();
        for (k = 0; k < 10; k++) begin
            send_frame(16'(rand_word()), 16'(rand_below(41)));
        end
        end_test("UDP frames with steady valid");

        start_test();
        for (k = 0; k < 3; k++) begin
            send_frame(16'(rand_word()), 16'd0);
        end
        end_test("UDP frames with data_len 0");

        start_test();
        gap_mode = 1'b1;
        for (k = 0; k < 10; k++) begin
            send_frame(16'(rand_word()), (k == 9) ? 16'd40 : 16'(rand_below(41)));
        end
        end_test("UDP frames with valid gaps");

        $display("Tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 10);
        $display("Timeout: no result after %0d cycles", LIMIT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule : tb_top

// ==== sim.f ====
verilog/udp_pkg.sv
verilog/udp_link_if.sv
verilog/link_timer.sv
verilog/sender_fsm.sv
verilog/frame_tx.sv
verilog/arp_rx.sv
verilog/udp_sender.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_top
FILELIST = sim.f
VFLAGS   = --binary --timing --assert --timescale 1ns/1ps -j 0
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
